// File: filelist.f
hw/ctrlPkg.sv
hw/decodeIf.sv
hw/instrClassifier.sv
hw/aluCtrl.sv
hw/memCtrl.sv
hw/pcCtrl.sv
hw/regWriteCtrl.sv
hw/ctrlDecoder.sv
tests/tbClock.sv
tests/ctrlDecoderTb.sv

// File: hw/aluCtrl.sv
`timescale 1ns/1ps

module aluCtrl import ctrlPkg::*; (
    decodeIf.sink                 dec,
    output logic [sel2W-1:0]      aluSrcA,
    output logic [aluSrcBW-1:0]   aluSrcB,
    output aluOpE                 aluOp,
    output logic                  abSwitch,
    output logic [sel2W-1:0]      extendCtrl,
    output logic                  extendMux
);

    logic             isShiftConst;
    logic             isShiftVar;
    logic [sel2W-1:0] extClass;
    aluOpE            kindOp;

    assign isShiftConst = dec.kind inside {instrSll, instrSrl, instrSra};
    assign isShiftVar   = dec.kind inside {instrSllv, instrSrlv, instrSrav};

    always_comb begin
        if (dec.isBranch) extClass = extSign;
        else if (dec.kind == instrLui) extClass = extUpper;
        else if (dec.kind inside {instrAndi, instrOri, instrXori}) extClass = extZero;
        else if (dec.isImmForm) extClass = extSign; // Arithmetic imm, loads, stores
        else extClass = extZero;
    end

    always_comb begin
        kindOp = aluAdd;
        if (dec.isBranch) kindOp = aluSub; // Compare by subtraction
        else if (dec.kind inside {instrSubu, instrSlt, instrSltu, instrSlti, instrSltiu})
            kindOp = aluSub;
        else if (dec.kind inside {instrAnd, instrAndi}) kindOp = aluAnd;
        else if (dec.kind inside {instrOr, instrOri}) kindOp = aluOr;
        else if (dec.kind inside {instrXor, instrXori}) kindOp = aluXor;
        else if (dec.kind inside {instrSll, instrSllv}) kindOp = aluSll;
        else if (dec.kind inside {instrSrl, instrSrlv}) kindOp = aluSrl;
        else if (dec.kind inside {instrSra, instrSrav}) kindOp = aluSra;
    end

    always_comb begin
        aluSrcA   = '0;
        aluSrcB   = srcBReg;
        aluOp     = aluAdd;
        abSwitch  = 1'b0;
        extendMux = 1'b0;
        case (dec.phase)
            phFetch: aluSrcB = srcBFour; // PC + 4
            phDecode: begin
                aluSrcB   = srcBBranchOff;
                extendMux = 1'b1;
            end
            phExecute: begin
                aluSrcA   = (dec.kind == instrLui) ? 2'd2 : 2'd1;
                aluOp     = kindOp;
                abSwitch  = isShiftConst | isShiftVar;
                extendMux = 1'b1;
                if (dec.isImmForm) aluSrcB = srcBImm;
                else if (isShiftConst) aluSrcB = srcBShamt;
                else if (isShiftVar) aluSrcB = srcBShiftReg;
                else if (dec.kind inside {instrJr, instrJalr}) aluSrcB = srcBJumpReg;
            end
            phMemory: begin
                aluSrcA   = 2'd1;
                extendMux = 1'b1;
            end
            phWriteback: begin
                aluSrcB   = srcBBranchOff;
                extendMux = 1'b1;
            end
            phStall, phLink: begin
                aluSrcB   = srcBFour;
                extendMux = 1'b1;
            end
            default: ;
        endcase
    end

    assign extendCtrl = extendMux ? extClass : extZero;

endmodule

// File: hw/ctrlDecoder.sv
`timescale 1ns/1ps

module ctrlDecoder import ctrlPkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  phaseE               phase,
    input  logic [5:0]          opcode,
    input  logic [5:0]          funct,
    input  logic [4:0]          rt,
    input  logic                link,
    output logic [sel2W-1:0]    aluSrcA,
    output logic [aluSrcBW-1:0] aluSrcB,
    output aluOpE               aluOp,
    output logic                abSwitch,
    output logic [sel2W-1:0]    extendCtrl,
    output logic                extendMux,
    output logic [sel2W-1:0]    iorD,
    output logic                memRead,
    output logic                memWrite,
    output storeSizeE           byteCtrl,
    output loadMaskE            maskCtrl,
    output logic [sel2W-1:0]    pcSrc,
    output logic                pcWrite,
    output logic                irWrite,
    output logic                altPcWrite,
    output logic                altPcMux,
    output logic [sel2W-1:0]    regDst,
    output logic [sel2W-1:0]    memToReg,
    output logic                regWrite,
    output logic                linkEn,
    output logic                linkIn
);

    decodeIf decBus ();

    instrClassifier u_classifier (
        .clk    (clk),
        .reset  (reset),
        .phase  (phase),
        .opcode (opcode),
        .funct  (funct),
        .rt     (rt),
        .dec    (decBus.source)
    );

    aluCtrl u_aluCtrl (
        .dec        (decBus.sink),
        .aluSrcA    (aluSrcA),
        .aluSrcB    (aluSrcB),
        .aluOp      (aluOp),
        .abSwitch   (abSwitch),
        .extendCtrl (extendCtrl),
        .extendMux  (extendMux)
    );

    memCtrl u_memCtrl (
        .dec      (decBus.sink),
        .iorD     (iorD),
        .memRead  (memRead),
        .memWrite (memWrite),
        .byteCtrl (byteCtrl),
        .maskCtrl (maskCtrl)
    );

    pcCtrl u_pcCtrl (
        .dec        (decBus.sink),
        .pcSrc      (pcSrc),
        .pcWrite    (pcWrite),
        .irWrite    (irWrite),
        .altPcWrite (altPcWrite),
        .altPcMux   (altPcMux)
    );

    regWriteCtrl u_regWriteCtrl (
        .dec      (decBus.sink),
        .link     (link),
        .regDst   (regDst),
        .memToReg (memToReg),
        .regWrite (regWrite),
        .linkEn   (linkEn),
        .linkIn   (linkIn)
    );

endmodule

// File: hw/ctrlPkg.sv
package ctrlPkg;

    typedef enum logic [3:0] {
        phFetch     = 4'd0,
        phDecode    = 4'd1,
        phExecute   = 4'd2,
        phMemory    = 4'd3,
        phWriteback = 4'd4,
        phStall     = 4'd5,
        phLink      = 4'd9
    } phaseE;

    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opRegimm  = 6'b000001,
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opBne     = 6'b000101,
        opBlez    = 6'b000110,
        opBgtz    = 6'b000111,
        opAddiu   = 6'b001001,
        opSlti    = 6'b001010,
        opSltiu   = 6'b001011,
        opAndi    = 6'b001100,
        opOri     = 6'b001101,
        opXori    = 6'b001110,
        opLui     = 6'b001111,
        opLb      = 6'b100000,
        opLh      = 6'b100001,
        opLw      = 6'b100011,
        opLbu     = 6'b100100,
        opLhu     = 6'b100101,
        opSb      = 6'b101000,
        opSh      = 6'b101001,
        opSw      = 6'b101011
    } opcodeE;

    typedef enum logic [5:0] {
        fnSll  = 6'b000000,
        fnSrl  = 6'b000010,
        fnSra  = 6'b000011,
        fnSllv = 6'b000100,
        fnSrlv = 6'b000110,
        fnSrav = 6'b000111,
        fnJr   = 6'b001000,
        fnJalr = 6'b001001,
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnXor  = 6'b100110,
        fnSlt  = 6'b101010,
        fnSltu = 6'b101011
    } functE;

    // REGIMM branches are told apart by rt
    localparam logic [4:0] rtBltz   = 5'b00000;
    localparam logic [4:0] rtBgez   = 5'b00001;
    localparam logic [4:0] rtBltzal = 5'b10000;
    localparam logic [4:0] rtBgezal = 5'b10001;

    typedef enum logic [5:0] {
        instrNop,
        instrAddu, instrSubu, instrAnd, instrOr, instrXor, instrSlt, instrSltu,
        instrAddiu, instrAndi, instrOri, instrXori, instrSlti, instrSltiu, instrLui,
        instrSll, instrSrl, instrSra, instrSllv, instrSrlv, instrSrav,
        instrLw, instrLb, instrLbu, instrLh, instrLhu,
        instrSw, instrSb, instrSh,
        instrBeq, instrBne, instrBgez, instrBgtz, instrBlez, instrBltz,
        instrBgezal, instrBltzal,
        instrJ, instrJal, instrJr, instrJalr
    } instrKindE;

    typedef enum logic [3:0] {
        aluAdd = 4'd0,
        aluSub = 4'd1,
        aluAnd = 4'd2,
        aluOr  = 4'd3,
        aluXor = 4'd4,
        aluSll = 4'd5,
        aluSrl = 4'd6,
        aluSra = 4'd7
    } aluOpE;

    typedef enum logic [2:0] {
        maskWord  = 3'd0,
        maskHalf  = 3'd1,
        maskHalfU = 3'd2,
        maskByte  = 3'd3,
        maskByteU = 3'd4
    } loadMaskE;

    typedef enum logic [1:0] {
        storeWord = 2'd0,
        storeByte = 2'd1,
        storeHalf = 2'd2
    } storeSizeE;

    localparam int sel2W    = 2;
    localparam int aluSrcBW = 3;

    localparam logic [aluSrcBW-1:0] srcBReg       = 3'd0;
    localparam logic [aluSrcBW-1:0] srcBFour      = 3'd1;
    localparam logic [aluSrcBW-1:0] srcBImm       = 3'd2;
    localparam logic [aluSrcBW-1:0] srcBBranchOff = 3'd3;
    localparam logic [aluSrcBW-1:0] srcBShamt     = 3'd4;
    localparam logic [aluSrcBW-1:0] srcBShiftReg  = 3'd5;
    localparam logic [aluSrcBW-1:0] srcBJumpReg   = 3'd6; // Register target for jr/jalr

    localparam logic [sel2W-1:0] extZero  = 2'd0;
    localparam logic [sel2W-1:0] extSign  = 2'd2;
    localparam logic [sel2W-1:0] extUpper = 2'd3;

endpackage

// File: hw/decodeIf.sv
`timescale 1ns/1ps

interface decodeIf import ctrlPkg::*; ();

    phaseE     phase;
    instrKindE kind;
    logic      isBranch;  // Any of the eight conditional branches
    logic      isImmForm; // I-type writing rt
    logic      isLinking;

    modport source (
        output phase, kind, isBranch, isImmForm, isLinking
    );

    modport sink (
        input phase, kind, isBranch, isImmForm, isLinking
    );

endinterface

// File: hw/instrClassifier.sv
`timescale 1ns/1ps

module instrClassifier import ctrlPkg::*; (
    input  logic           clk,
    input  logic           reset,
    input  phaseE          phase,
    input  logic [5:0]     opcode,
    input  logic [5:0]     funct,
    input  logic [4:0]     rt,
    decodeIf.source        dec
);

    instrKindE freshKind;
    instrKindE heldKind;
    instrKindE curKind;

    always_comb begin
        freshKind = instrNop;
        case (opcode)
            opSpecial: begin
                case (funct)
                    fnSll:   freshKind = instrSll;
                    fnSrl:   freshKind = instrSrl;
                    fnSra:   freshKind = instrSra;
                    fnSllv:  freshKind = instrSllv;
                    fnSrlv:  freshKind = instrSrlv;
                    fnSrav:  freshKind = instrSrav;
                    fnJr:    freshKind = instrJr;
                    fnJalr:  freshKind = instrJalr;
                    fnAddu:  freshKind = instrAddu;
                    fnSubu:  freshKind = instrSubu;
                    fnAnd:   freshKind = instrAnd;
                    fnOr:    freshKind = instrOr;
                    fnXor:   freshKind = instrXor;
                    fnSlt:   freshKind = instrSlt;
                    fnSltu:  freshKind = instrSltu;
                    default: freshKind = instrNop;
                endcase
            end
            opRegimm: begin
                case (rt)
                    rtBltz:   freshKind = instrBltz;
                    rtBgez:   freshKind = instrBgez;
                    rtBltzal: freshKind = instrBltzal;
                    rtBgezal: freshKind = instrBgezal;
                    default:  freshKind = instrNop;
                endcase
            end
            opJ:     freshKind = instrJ;
            opJal:   freshKind = instrJal;
            opBeq:   freshKind = instrBeq;
            opBne:   freshKind = instrBne;
            opBlez:  freshKind = (rt == 5'd0) ? instrBlez : instrNop; // rt must be zero
            opBgtz:  freshKind = (rt == 5'd0) ? instrBgtz : instrNop;
            opAddiu: freshKind = instrAddiu;
            opSlti:  freshKind = instrSlti;
            opSltiu: freshKind = instrSltiu;
            opAndi:  freshKind = instrAndi;
            opOri:   freshKind = instrOri;
            opXori:  freshKind = instrXori;
            opLui:   freshKind = instrLui;
            opLb:    freshKind = instrLb;
            opLh:    freshKind = instrLh;
            opLw:    freshKind = instrLw;
            opLbu:   freshKind = instrLbu;
            opLhu:   freshKind = instrLhu;
            opSb:    freshKind = instrSb;
            opSh:    freshKind = instrSh;
            opSw:    freshKind = instrSw;
            default: freshKind = instrNop;
        endcase
    end

    // Class is captured on every decode cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            heldKind <= instrNop;
        end else if (phase == phDecode) begin
            heldKind <= freshKind;
        end
    end

    assign curKind = (phase == phDecode) ? freshKind : heldKind;

    assign dec.phase     = phase;
    assign dec.kind      = curKind;
    assign dec.isBranch  = curKind inside {instrBeq, instrBne, instrBgez, instrBgtz,
                                           instrBlez, instrBltz, instrBgezal, instrBltzal};
    assign dec.isImmForm = curKind inside {instrAddiu, instrAndi, instrOri, instrXori,
                                           instrSlti, instrSltiu, instrLui,
                                           instrLw, instrLb, instrLbu, instrLh, instrLhu,
                                           instrSw, instrSb, instrSh};
    assign dec.isLinking = curKind inside {instrBgezal, instrBltzal, instrJal, instrJalr};

endmodule

// File: hw/memCtrl.sv
`timescale 1ns/1ps

module memCtrl import ctrlPkg::*; (
    decodeIf.sink            dec,
    output logic [sel2W-1:0] iorD,
    output logic             memRead,
    output logic             memWrite,
    output storeSizeE        byteCtrl,
    output loadMaskE         maskCtrl
);

    logic isStore;

    assign isStore = dec.kind inside {instrSw, instrSb, instrSh};

    always_comb begin
        iorD     = '0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        byteCtrl = storeWord;
        maskCtrl = maskWord;
        case (dec.phase)
            phFetch, phDecode, phExecute, phLink: memRead = 1'b1;
            phMemory: begin
                memWrite = isStore;
                memRead  = ~isStore;
                iorD     = (dec.kind inside {instrLw, instrSw}) ? 2'd1 : 2'd2; // Word or sub-word path
                case (dec.kind)
                    instrSb: byteCtrl = storeByte;
                    instrSh: byteCtrl = storeHalf;
                    default: byteCtrl = storeWord;
                endcase
            end
            phWriteback: begin
                memRead = 1'b1;
                case (dec.kind)
                    instrLb:  maskCtrl = maskByte;
                    instrLbu: maskCtrl = maskByteU;
                    instrLh:  maskCtrl = maskHalf;
                    instrLhu: maskCtrl = maskHalfU;
                    default:  maskCtrl = maskWord;
                endcase
            end
            default: ; // Stall keeps memory idle
        endcase
    end

endmodule

// File: hw/pcCtrl.sv
`timescale 1ns/1ps

module pcCtrl import ctrlPkg::*; (
    decodeIf.sink            dec,
    output logic [sel2W-1:0] pcSrc,
    output logic             pcWrite,
    output logic             irWrite,
    output logic             altPcWrite,
    output logic             altPcMux
);

    logic isJump;
    logic isJumpReg;

    assign isJump    = dec.kind inside {instrJ, instrJal};
    assign isJumpReg = dec.kind inside {instrJr, instrJalr};

    always_comb begin
        pcSrc      = '0;
        pcWrite    = 1'b0;
        irWrite    = 1'b0;
        altPcWrite = 1'b0;
        altPcMux   = 1'b0;
        case (dec.phase)
            phFetch: begin
                irWrite = 1'b1;
                pcWrite = 1'b1;
            end
            phDecode: begin
                pcSrc      = 2'd2;
                altPcWrite = isJump; // Jump target known at decode
                altPcMux   = 1'b1;
            end
            phExecute: begin
                pcSrc      = 2'd1;
                altPcWrite = dec.isBranch;
            end
            phMemory: begin
                pcSrc      = 2'd1;
                altPcWrite = isJumpReg;
            end
            phWriteback: begin
                pcSrc    = 2'd2;
                altPcMux = 1'b1;
            end
            phStall: altPcMux = 1'b1;
            phLink: begin
                pcSrc      = 2'd3; // Redirect to alternate PC
                pcWrite    = 1'b1;
                altPcWrite = isJump;
                altPcMux   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: hw/regWriteCtrl.sv
`timescale 1ns/1ps

module regWriteCtrl import ctrlPkg::*; (
    decodeIf.sink            dec,
    input  logic             link,
    output logic [sel2W-1:0] regDst,
    output logic [sel2W-1:0] memToReg,
    output logic             regWrite,
    output logic             linkEn,
    output logic             linkIn
);

    logic isRType;
    logic isSetLess;
    logic isAluResult;
    logic isLoad;

    assign isRType = dec.kind inside {instrAddu, instrSubu, instrAnd, instrOr, instrXor,
                                      instrSlt, instrSltu, instrSll, instrSrl, instrSra,
                                      instrSllv, instrSrlv, instrSrav, instrJr, instrJalr};
    assign isSetLess   = dec.kind inside {instrSlt, instrSltu, instrSlti, instrSltiu};
    assign isAluResult = (isRType & ~(dec.kind inside {instrJr, instrJalr}))
                       | (dec.isImmForm & ~isLoad
                          & ~(dec.kind inside {instrSw, instrSb, instrSh}));
    assign isLoad = dec.kind inside {instrLw, instrLb, instrLbu, instrLh, instrLhu};

    always_comb begin
        regDst   = '0;
        memToReg = '0;
        regWrite = 1'b0;
        linkEn   = 1'b0;
        linkIn   = 1'b0;
        case (dec.phase)
            phDecode, phExecute, phMemory: begin
                if (dec.isImmForm) regDst = 2'd0; // rt destination
                else if (dec.phase == phDecode && dec.kind inside {instrJal, instrJalr})
                    regDst = 2'd2;
                else if (isRType) regDst = 2'd1;
                if (dec.phase == phExecute) begin
                    linkEn = 1'b1;
                    linkIn = dec.isLinking;
                end
                if (dec.phase == phMemory) begin
                    memToReg = isSetLess ? 2'd2 : 2'd0;
                    regWrite = isAluResult;
                end
            end
            phWriteback: begin
                memToReg = 2'd1;
                regWrite = isLoad;
            end
            phLink: begin
                regDst   = 2'd2; // Return address register
                memToReg = 2'd3;
                regWrite = link;
                linkEn   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

// File: tests/ctrlDecoderTb.sv
`timescale 1ns/1ps

module ctrlDecoderTb import ctrlPkg::*; ();

    localparam int clkPeriod      = 40;
    localparam int aluSeqs        = 12;
    localparam int branchSeqs     = 10;
    localparam int memSeqs        = 10;
    localparam int mixSeqs        = 16;
    localparam int numSeqs        = aluSeqs + branchSeqs + memSeqs + mixSeqs;
    localparam int watchdogCycles = numSeqs * 7 + 20;

    typedef struct packed {
        logic [1:0] aluSrcA;
        logic [2:0] aluSrcB;
        logic [3:0] aluOp;
        logic       abSwitch;
        logic [1:0] extendCtrl;
        logic       extendMux;
        logic [1:0] iorD;
        logic       memRead;
        logic       memWrite;
        logic [1:0] byteCtrl;
        logic [2:0] maskCtrl;
        logic [1:0] pcSrc;
        logic       pcWrite;
        logic       irWrite;
        logic       altPcWrite;
        logic       altPcMux;
        logic [1:0] regDst;
        logic [1:0] memToReg;
        logic       regWrite;
        logic       linkEn;
        logic       linkIn;
    } ctrlT;

    logic clk;
    logic reset;
    phaseE phase;
    logic [5:0] opcode;
    logic [5:0] funct;
    logic [4:0] rt;
    logic link;
    logic [1:0] aluSrcA;
    logic [2:0] aluSrcB;
    aluOpE aluOp;
    logic abSwitch;
    logic [1:0] extendCtrl;
    logic extendMux;
    logic [1:0] iorD;
    logic memRead;
    logic memWrite;
    storeSizeE byteCtrl;
    loadMaskE maskCtrl;
    logic [1:0] pcSrc;
    logic pcWrite;
    logic irWrite;
    logic altPcWrite;
    logic altPcMux;
    logic [1:0] regDst;
    logic [1:0] memToReg;
    logic regWrite;
    logic linkEn;
    logic linkIn;

    logic [31:0] rnd;
    int errors;
    instrKindE expKind; // Class the DUT should be holding
    phaseE seqPhases [0:6];

    tbClock u_clock (.clk(clk), .reset(reset));

    ctrlDecoder u_dut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Builds opcode, funct and rt for a class; unused fields stay random
    function automatic logic [16:0] encodeInstr(input instrKindE k, input logic [31:0] r);
        logic [5:0] op;
        logic [5:0] fn;
        logic [4:0] rtv;
        op  = opSpecial;
        fn  = r[5:0];
        rtv = r[10:6];
        case (k)
            instrAddu:   fn = fnAddu;
            instrSubu:   fn = fnSubu;
            instrAnd:    fn = fnAnd;
            instrOr:     fn = fnOr;
            instrXor:    fn = fnXor;
            instrSlt:    fn = fnSlt;
            instrSltu:   fn = fnSltu;
            instrSll:    fn = fnSll;
            instrSrl:    fn = fnSrl;
            instrSra:    fn = fnSra;
            instrSllv:   fn = fnSllv;
            instrSrlv:   fn = fnSrlv;
            instrSrav:   fn = fnSrav;
            instrJr:     fn = fnJr;
            instrJalr:   fn = fnJalr;
            instrAddiu:  op = opAddiu;
            instrAndi:   op = opAndi;
            instrOri:    op = opOri;
            instrXori:   op = opXori;
            instrSlti:   op = opSlti;
            instrSltiu:  op = opSltiu;
            instrLui:    op = opLui;
            instrLw:     op = opLw;
            instrLb:     op = opLb;
            instrLbu:    op = opLbu;
            instrLh:     op = opLh;
            instrLhu:    op = opLhu;
            instrSw:     op = opSw;
            instrSb:     op = opSb;
            instrSh:     op = opSh;
            instrBeq:    op = opBeq;
            instrBne:    op = opBne;
            instrBgtz:   op = opBgtz;
            instrBlez:   op = opBlez;
            instrJ:      op = opJ;
            instrJal:    op = opJal;
            instrBltz, instrBgez, instrBltzal, instrBgezal: op = opRegimm;
            default: ;
        endcase
        case (k)
            instrBltz:   rtv = rtBltz;
            instrBgez:   rtv = rtBgez;
            instrBltzal: rtv = rtBltzal;
            instrBgezal: rtv = rtBgezal;
            instrBlez, instrBgtz: rtv = 5'd0;
            default: ;
        endcase
        return {op, fn, rtv};
    endfunction

    function automatic ctrlT expectedCtrl(input phaseE ph, input instrKindE k, input logic lnk);
        ctrlT e;
        logic branch;
        logic load;
        logic store;
        logic imm;
        logic shiftC;
        logic shiftV;
        logic jump;
        logic jumpReg;
        logic rType;
        logic [1:0] rdBase;
        branch  = k inside {instrBeq, instrBne, instrBgez, instrBgtz, instrBlez, instrBltz,
                            instrBgezal, instrBltzal};
        load    = k inside {instrLw, instrLb, instrLbu, instrLh, instrLhu};
        store   = k inside {instrSw, instrSb, instrSh};
        imm     = load | store | (k inside {instrAddiu, instrAndi, instrOri, instrXori,
                                            instrSlti, instrSltiu, instrLui});
        shiftC  = k inside {instrSll, instrSrl, instrSra};
        shiftV  = k inside {instrSllv, instrSrlv, instrSrav};
        jump    = k inside {instrJ, instrJal};
        jumpReg = k inside {instrJr, instrJalr};
        rType   = shiftC | shiftV | jumpReg
                | (k inside {instrAddu, instrSubu, instrAnd, instrOr, instrXor, instrSlt, instrSltu});
        rdBase  = (rType && !imm) ? 2'd1 : 2'd0;
        e = '0;
        case (ph)
            phFetch: begin
                e.irWrite = 1'b1;
                e.pcWrite = 1'b1;
                e.memRead = 1'b1;
                e.aluSrcB = srcBFour;
            end
            phDecode: begin
                e.aluSrcB    = srcBBranchOff;
                e.memRead    = 1'b1;
                e.pcSrc      = 2'd2;
                e.altPcWrite = jump;
                e.altPcMux   = 1'b1;
                e.regDst     = (!imm && (k inside {instrJal, instrJalr})) ? 2'd2 : rdBase;
            end
            phExecute: begin
                e.aluSrcA = (k == instrLui) ? 2'd2 : 2'd1;
                if (imm) e.aluSrcB = srcBImm;
                else if (shiftC) e.aluSrcB = srcBShamt;
                else if (shiftV) e.aluSrcB = srcBShiftReg;
                else if (jumpReg) e.aluSrcB = 3'd6;
                case (k)
                    instrSubu, instrSlt, instrSltu, instrSlti, instrSltiu: e.aluOp = aluSub;
                    instrAnd, instrAndi: e.aluOp = aluAnd;
                    instrOr, instrOri:   e.aluOp = aluOr;
                    instrXor, instrXori: e.aluOp = aluXor;
                    instrSll, instrSllv: e.aluOp = aluSll;
                    instrSrl, instrSrlv: e.aluOp = aluSrl;
                    instrSra, instrSrav: e.aluOp = aluSra;
                    default: e.aluOp = branch ? aluSub : aluAdd;
                endcase
                e.abSwitch   = shiftC | shiftV;
                e.memRead    = 1'b1;
                e.pcSrc      = 2'd1;
                e.altPcWrite = branch;
                e.regDst     = rdBase;
                e.linkEn     = 1'b1;
                e.linkIn     = k inside {instrBgezal, instrBltzal, instrJal, instrJalr};
            end
            phMemory: begin
                e.aluSrcA    = 2'd1;
                e.memRead    = !store;
                e.memWrite   = store;
                e.iorD       = (k inside {instrLw, instrSw}) ? 2'd1 : 2'd2;
                e.byteCtrl   = (k == instrSb) ? 2'd1 : (k == instrSh) ? 2'd2 : 2'd0;
                e.pcSrc      = 2'd1;
                e.altPcWrite = jumpReg;
                e.regDst     = rdBase;
                e.memToReg   = (k inside {instrSlt, instrSltu, instrSlti, instrSltiu}) ? 2'd2 : 2'd0;
                e.regWrite   = (rType && !jumpReg) || (imm && !load && !store);
            end
            phWriteback: begin
                e.aluSrcB  = srcBBranchOff;
                e.memRead  = 1'b1;
                case (k)
                    instrLb:  e.maskCtrl = 3'd3;
                    instrLbu: e.maskCtrl = 3'd4;
                    instrLh:  e.maskCtrl = 3'd1;
                    instrLhu: e.maskCtrl = 3'd2;
                    default:  e.maskCtrl = 3'd0;
                endcase
                e.pcSrc    = 2'd2;
                e.altPcMux = 1'b1;
                e.memToReg = 2'd1;
                e.regWrite = load;
            end
            phStall: begin
                e.aluSrcB  = srcBFour;
                e.altPcMux = 1'b1;
            end
            phLink: begin
                e.aluSrcB    = srcBFour;
                e.memRead    = 1'b1;
                e.pcSrc      = 2'd3;
                e.pcWrite    = 1'b1;
                e.altPcWrite = jump;
                e.altPcMux   = 1'b1;
                e.regDst     = 2'd2;
                e.memToReg   = 2'd3;
                e.regWrite   = lnk;
                e.linkEn     = 1'b1;
            end
            default: ; // Unlisted phase codes drive nothing
        endcase
        e.extendMux = ph inside {phDecode, phExecute, phMemory, phWriteback, phStall, phLink};
        if (!e.extendMux) e.extendCtrl = extZero;
        else if (branch) e.extendCtrl = extSign;
        else if (k == instrLui) e.extendCtrl = extUpper;
        else if (k inside {instrAndi, instrOri, instrXori}) e.extendCtrl = extZero;
        else if (imm) e.extendCtrl = extSign;
        return e;
    endfunction

    task automatic checkField(input string name, input logic [31:0] expVal,
                              input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            errors++;
            $display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expVal, actVal);
            $display("Test FAILED");
            $fatal(1, "Stopped at first output mismatch");
        end
    endtask

    task automatic checkOutputs();
        ctrlT e;
        e = expectedCtrl(phase, expKind, link);
        checkField("aluSrcA", e.aluSrcA, aluSrcA);
        checkField("aluSrcB", e.aluSrcB, aluSrcB);
        checkField("aluOp", e.aluOp, aluOp);
        checkField("abSwitch", e.abSwitch, abSwitch);
        checkField("extendCtrl", e.extendCtrl, extendCtrl);
        checkField("extendMux", e.extendMux, extendMux);
        checkField("iorD", e.iorD, iorD);
        checkField("memRead", e.memRead, memRead);
        checkField("memWrite", e.memWrite, memWrite);
        checkField("byteCtrl", e.byteCtrl, byteCtrl);
        checkField("maskCtrl", e.maskCtrl, maskCtrl);
        checkField("pcSrc", e.pcSrc, pcSrc);
        checkField("pcWrite", e.pcWrite, pcWrite);
        checkField("irWrite", e.irWrite, irWrite);
        checkField("altPcWrite", e.altPcWrite, altPcWrite);
        checkField("altPcMux", e.altPcMux, altPcMux);
        checkField("regDst", e.regDst, regDst);
        checkField("memToReg", e.memToReg, memToReg);
        checkField("regWrite", e.regWrite, regWrite);
        checkField("linkEn", e.linkEn, linkEn);
        checkField("linkIn", e.linkIn, linkIn);
    endtask

    task automatic randomKind(input int lo, input int hi, output instrKindE k);
        rnd = xorshift(rnd);
        k = instrKindE'(lo + (rnd % (hi - lo + 1)));
    endtask

    // One instruction through all seven listed phases
    task automatic runSequence(input instrKindE k, input logic scramble);
        for (int i = 0; i < 7; i++) begin
            @(posedge clk);
            #2;
            rnd   = xorshift(rnd);
            phase = seqPhases[i];
            link  = rnd[31];
            if (seqPhases[i] == phDecode) begin
                {opcode, funct, rt} = encodeInstr(k, rnd);
                expKind = k;
            end else if (scramble || seqPhases[i] == phFetch) begin
                {opcode, funct, rt} = rnd[16:0]; // Fields must be ignored here
            end
            @(negedge clk);
            checkOutputs();
        end
    endtask

    initial begin
        instrKindE k;
        rnd       = 32'h04046e2a;
        errors    = 0;
        seqPhases = '{phFetch, phDecode, phExecute, phMemory, phWriteback, phStall, phLink};
        phase     = phExecute;
        opcode    = 6'd0;
        funct     = 6'd0;
        rt        = 5'd0;
        link      = 1'b0;
        expKind   = instrNop;
        @(negedge reset);
        @(negedge clk);
        checkOutputs(); // Nothing decoded yet
        @(posedge clk);
        #2;
        phase = phaseE'(4'd12);
        @(negedge clk);
        checkOutputs();
        repeat (aluSeqs) begin
            randomKind(1, 20, k);
            runSequence(k, 1'b0);
        end
        repeat (branchSeqs) begin
            randomKind(29, 36, k);
            runSequence(k, 1'b0);
        end
        repeat (memSeqs) begin
            randomKind(21, 28, k);
            runSequence(k, 1'b0);
        end
        repeat (mixSeqs) begin
            randomKind(1, 40, k);
            runSequence(k, 1'b1);
        end
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Watchdog expired before all sequences finished");
        $display("Test FAILED");
        $fatal(1, "Simulation timed out");
    end

endmodule

// File: tests/tbClock.sv
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic reset
);

    localparam int halfPeriod  = 20; // 40 ns period
    localparam int resetCycles = 8;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule
